// ==== ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

//////////////////////////////////////////////////
// RV64 integer execute stage sizes
//////////////////////////////////////////////////

// Full register width
`define EX_XLEN 64

// Operand width of the *W instructions
`define EX_WORD_W 32

// No compressed instructions, so every step is 4 bytes
`define EX_INSN_BYTES 4

`endif

// ==== ex_pkg.sv ====
`include "ex_cfg.svh"

package ex_pkg;

    //////////////////////////////////////////////////
    // Data word
    //////////////////////////////////////////////////

    typedef logic [`EX_XLEN-1:0] xword_t;

    //////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////

    typedef enum logic [3:0]
    {
        alu_idle,
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_pass
    } alu_op_t;

    //////////////////////////////////////////////////
    // Control transfer kinds
    //////////////////////////////////////////////////

    // Jumps first, then the six conditional branches
    typedef enum logic [3:0]
    {
        br_none,
        br_jal,
        br_jalr,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_kind_t;

endpackage

// ==== ex_if.sv ====
// Operation accepted into the stage
interface ex_op_if;
    import ex_pkg::*;

    alu_op_t    op;
    logic       word;
    br_kind_t   br_kind;
    xword_t     rs1;
    xword_t     rs2;
    xword_t     pc;
    xword_t     imm;

    modport src (output op, word, br_kind, rs1, rs2, pc, imm);

    modport alu (input op, word, rs1, rs2);

    modport br  (input br_kind, rs1, rs2, pc, imm);

endinterface

// Outcome of branch resolution
interface br_res_if;
    import ex_pkg::*;

    logic       taken;
    xword_t     target;
    xword_t     link;
    logic       misaligned;

    modport drv  (output taken, target, link, misaligned);

    modport sink (input taken, target, link, misaligned);

endinterface

// ==== int_alu.sv ====
`include "ex_cfg.svh"

module int_alu
(
    ex_op_if.alu            ops,
    output ex_pkg::xword_t  result
);
    import ex_pkg::*;

    localparam int SH_W  = $clog2(`EX_XLEN);
    localparam int WSH_W = $clog2(`EX_WORD_W);

    logic [SH_W-1:0]        shamt;
    logic [`EX_WORD_W-1:0]  a_w;
    logic [`EX_WORD_W-1:0]  b_w;
    logic [`EX_WORD_W-1:0]  add_w;
    logic [`EX_WORD_W-1:0]  sub_w;
    logic [`EX_WORD_W-1:0]  sll_w;
    logic [`EX_WORD_W-1:0]  srl_w;
    logic [`EX_WORD_W-1:0]  sra_w;
    xword_t                 sra_x;

    function automatic xword_t sext_word(input logic [`EX_WORD_W-1:0] v);
        return {{(`EX_XLEN-`EX_WORD_W){v[`EX_WORD_W-1]}}, v};
    endfunction

    // Word mode only sees the low 5 bits of the shift amount
    assign shamt = ops.word ? SH_W'(ops.rs2[WSH_W-1:0]) : ops.rs2[SH_W-1:0];

    //////////////////////////////////////////////////
    // 32-bit word results
    //////////////////////////////////////////////////

    assign a_w   = ops.rs1[`EX_WORD_W-1:0];
    assign b_w   = ops.rs2[`EX_WORD_W-1:0];
    assign add_w = a_w + b_w;
    assign sub_w = a_w - b_w;
    assign sll_w = a_w << shamt[WSH_W-1:0];
    assign srl_w = a_w >> shamt[WSH_W-1:0];
    assign sra_w = $signed(a_w) >>> shamt[WSH_W-1:0];

    // Full-width arithmetic shift
    assign sra_x = $signed(ops.rs1) >>> shamt;

    //////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////

    always_comb
    begin
        case (ops.op)
            alu_idle:
                result = '0;
            alu_add:
                result = ops.word ? sext_word(add_w) : ops.rs1 + ops.rs2;
            alu_sub:
                result = ops.word ? sext_word(sub_w) : ops.rs1 - ops.rs2;
            alu_sll:
                result = ops.word ? sext_word(sll_w) : ops.rs1 << shamt;
            alu_srl:
                result = ops.word ? sext_word(srl_w) : ops.rs1 >> shamt;
            alu_sra:
                result = ops.word ? sext_word(sra_w) : sra_x;
            alu_and:
                result = ops.rs1 & ops.rs2;
            alu_or:
                result = ops.rs1 | ops.rs2;
            alu_xor:
                result = ops.rs1 ^ ops.rs2;
            alu_slt:
                result = xword_t'($signed(ops.rs1) < $signed(ops.rs2));
            alu_sltu:
                result = xword_t'(ops.rs1 < ops.rs2);
            alu_pass:
                result = ops.rs2;
            default:
                result = '0;
        endcase
    end

endmodule

// ==== branch_resolver.sv ====
`include "ex_cfg.svh"

module branch_resolver
(
    ex_op_if.br     ops,
    br_res_if.drv   res
);
    import ex_pkg::*;

    localparam int ALIGN_W = $clog2(`EX_INSN_BYTES);

    logic       eq;
    logic       lt;
    logic       ltu;
    logic       taken;
    xword_t     base;
    xword_t     target;

    //////////////////////////////////////////////////
    // Operand compare
    //////////////////////////////////////////////////

    assign eq  = ops.rs1 == ops.rs2;
    assign lt  = $signed(ops.rs1) < $signed(ops.rs2);
    assign ltu = ops.rs1 < ops.rs2;

    always_comb
    begin
        case (ops.br_kind)
            br_none:
                taken = 1'b0;
            br_jal, br_jalr:
                taken = 1'b1;
            br_eq:
                taken = eq;
            br_ne:
                taken = !eq;
            br_lt:
                taken = lt;
            br_ge:
                taken = !lt;
            br_ltu:
                taken = ltu;
            br_geu:
                taken = !ltu;
            default:
                taken = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Target and link
    //////////////////////////////////////////////////

    // Register-relative only for jalr
    assign base   = (ops.br_kind == br_jalr) ? ops.rs1 : ops.pc;
    assign target = base + ops.imm;

    assign res.taken      = taken;
    assign res.target     = target;
    assign res.link       = ops.pc + xword_t'(`EX_INSN_BYTES);
    // Untaken branches never fault on their target
    assign res.misaligned = taken && (|target[ALIGN_W-1:0]);

endmodule

// ==== ex_result_reg.sv ====
module ex_result_reg
(
    input  logic            CLK,
    input  logic            RST,
    ex_op_if.br             ops,
    input  ex_pkg::xword_t  alu_result,
    br_res_if.sink          br,
    input  logic            in_valid,
    output logic            in_ready,
    output logic            out_valid,
    input  logic            out_ready,
    output ex_pkg::xword_t  result,
    output logic            redirect,
    output ex_pkg::xword_t  redirect_pc,
    output logic            target_misaligned
);
    import ex_pkg::*;

    logic       accept;
    logic       is_jump;
    logic       redirect_d;
    xword_t     result_d;

    // Jumps write back the link address
    assign is_jump    = (ops.br_kind == br_jal) || (ops.br_kind == br_jalr);
    assign result_d   = is_jump ? br.link : alu_result;
    assign redirect_d = br.taken && !br.misaligned;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Slot is free when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            out_valid         <= 1'b0;
            redirect          <= 1'b0;
            target_misaligned <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
            if (accept)
            begin
                redirect          <= redirect_d;
                target_misaligned <= br.misaligned;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            result      <= result_d;
            redirect_pc <= br.target;
        end
    end

endmodule

// ==== ex_stage.sv ====
module ex_stage
(
    input  logic                CLK,
    input  logic                RST,

    input  logic                in_valid,
    output logic                in_ready,
    input  ex_pkg::alu_op_t     op,
    input  logic                word,
    input  ex_pkg::br_kind_t    br_kind,
    input  ex_pkg::xword_t      rs1,
    input  ex_pkg::xword_t      rs2,
    input  ex_pkg::xword_t      pc,
    input  ex_pkg::xword_t      imm,

    output logic                out_valid,
    input  logic                out_ready,
    output ex_pkg::xword_t      result,
    output logic                redirect,
    output ex_pkg::xword_t      redirect_pc,
    output logic                target_misaligned
);

    ex_op_if    ops ();
    br_res_if   br_res ();

    ex_pkg::xword_t alu_result;

    //////////////////////////////////////////////////
    // Operation bus
    //////////////////////////////////////////////////

    assign ops.op      = op;
    assign ops.word    = word;
    assign ops.br_kind = br_kind;
    assign ops.rs1     = rs1;
    assign ops.rs2     = rs2;
    assign ops.pc      = pc;
    assign ops.imm     = imm;

    //////////////////////////////////////////////////
    // ALU and branch unit side by side
    //////////////////////////////////////////////////

    int_alu u_alu
    (
        .ops    (ops.alu),
        .result (alu_result)
    );

    branch_resolver u_branch
    (
        .ops    (ops.br),
        .res    (br_res.drv)
    );

    // Output register with valid/ready
    ex_result_reg u_result
    (
        .CLK               (CLK),
        .RST               (RST),
        .ops               (ops.br),
        .alu_result        (alu_result),
        .br                (br_res.sink),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .result            (result),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .target_misaligned (target_misaligned)
    );

endmodule

// ==== ex_checker.sv ====
module ex_checker
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            in_valid,
    input  logic            in_ready,
    input  ex_pkg::xword_t  exp_result,
    input  logic            exp_redirect,
    input  ex_pkg::xword_t  exp_redirect_pc,
    input  logic            exp_misaligned,
    input  logic            out_valid,
    input  logic            out_ready,
    input  ex_pkg::xword_t  result,
    input  logic            redirect,
    input  ex_pkg::xword_t  redirect_pc,
    input  logic            target_misaligned,
    input  logic            stim_done,
    output int              pending,
    output int              mismatch_errs,
    output int              protocol_errs,
    output logic            drain_failed
);
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int DRAIN_LIMIT = 100;

    typedef struct packed
    {
        xword_t result;
        logic   redirect;
        xword_t redirect_pc;
        logic   misaligned;
    } out_t;

    out_t   exp_q[$];
    out_t   expv;
    out_t   held;
    out_t   seen;
    logic   stalled;
    int     drain_cycles;

    assign seen = {result, redirect, redirect_pc, target_misaligned};

    task automatic compare_field(input string name, input xword_t expected, input xword_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %0h, got %0h", name, expected, actual);
            mismatch_errs++;
        end
    endtask

    // Everything sampled mid-cycle, away from the clock edge
    always @(negedge CLK)
    begin
        if (RST)
        begin
            exp_q.delete();
            stalled      = 1'b0;
            drain_cycles = 0;
            drain_failed = 1'b0;
        end
        else
        begin
            if (stalled && !out_valid)
            begin
                $display("out_valid dropped while the output was stalled");
                protocol_errs++;
            end
            else if (stalled && seen !== held)
            begin
                $display("Outputs changed while held by out_ready low");
                protocol_errs++;
            end

            if (out_valid && exp_q.size() == 0)
            begin
                $display("out_valid is high but no item is outstanding");
                protocol_errs++;
            end
            else if (out_valid && out_ready)
            begin
                expv = exp_q.pop_front();
                compare_field("result", expv.result, result);
                compare_field("redirect", xword_t'(expv.redirect), xword_t'(redirect));
                compare_field("redirect_pc", expv.redirect_pc, redirect_pc);
                compare_field("target_misaligned", xword_t'(expv.misaligned),
                              xword_t'(target_misaligned));
            end

            stalled = out_valid && !out_ready;
            held    = seen;

            // Item goes in at the edge that follows
            if (in_valid && in_ready)
                exp_q.push_back({exp_result, exp_redirect, exp_redirect_pc, exp_misaligned});

            if (stim_done && exp_q.size() != 0 && !drain_failed)
            begin
                drain_cycles++;
                if (drain_cycles >= DRAIN_LIMIT)
                begin
                    $display("Items still outstanding %0d cycles after the last input",
                             DRAIN_LIMIT);
                    protocol_errs++;
                    drain_failed = 1'b1;
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

// ==== tb_ex_stage.sv ====
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int unsigned SEED = 32'h2c36;
    localparam int NVEC = 37;
    localparam int WAIT_LIMIT = 50;
    localparam int DRAIN_WAIT = 150;
    localparam xword_t SIGN_BIT = 64'h8000000000000000;

    typedef struct packed
    {
        alu_op_t    op;
        logic       word;
        br_kind_t   kind;
        xword_t     rs1;
        xword_t     rs2;
        xword_t     pc;
        xword_t     imm;
        xword_t     res;
        logic       redir;
        xword_t     rpc;
        logic       mis;
    } vec_t;

    logic       CLK = 1'b0;
    logic       RST;
    logic       in_valid;
    logic       in_ready;
    alu_op_t    op;
    logic       word;
    br_kind_t   br_kind;
    xword_t     rs1;
    xword_t     rs2;
    xword_t     pc;
    xword_t     imm;
    logic       out_valid;
    logic       out_ready = 1'b1;
    xword_t     result;
    logic       redirect;
    xword_t     redirect_pc;
    logic       target_misaligned;
    xword_t     exp_result;
    xword_t     exp_redirect_pc;
    logic       exp_redirect;
    logic       exp_misaligned;
    logic       stim_done;
    logic       backpressure;
    logic       bp_sampled;
    logic       drain_failed;
    int         pending;
    int         mismatch_errs;
    int         protocol_errs;
    int         tb_errs;
    int         nvec;
    int         waited;
    vec_t       vecs[NVEC];

    ex_stage i_dut (.*);

    ex_checker i_chk (.*);

    always #10 CLK = ~CLK;

    // About one cycle in three stalled once back-pressure is on
    always @(posedge CLK)
    begin
        bp_sampled = backpressure;
        #1;
        if (bp_sampled)
            out_ready = ($urandom % 3) != 0;
        else
            out_ready = 1'b1;
    end

    task automatic add_vec(input alu_op_t o, input logic w, input br_kind_t k,
                           input xword_t a, input xword_t b, input xword_t p, input xword_t i,
                           input xword_t r, input logic rd, input xword_t rp, input logic m);
        vecs[nvec] = '{o, w, k, a, b, p, i, r, rd, rp, m};
        nvec++;
    endtask

    //////////////////////////////////////////////////
    // Vector table
    //////////////////////////////////////////////////

    task automatic load_vectors;
        // op, word, kind, rs1, rs2, pc, imm, result, redirect, redirect_pc, misaligned
        add_vec(alu_idle, 0, br_none, 3, 4, 0, 0, 0, 0, 0, 0);
        add_vec(alu_add, 0, br_none, 5, 7, 0, 0, 12, 0, 0, 0);
        add_vec(alu_add, 0, br_none, SIGN_BIT - 1, 1, 0, 0, SIGN_BIT, 0, 0, 0);
        add_vec(alu_sub, 0, br_none, 3, 5, 0, 0, -64'd2, 0, 0, 0);
        add_vec(alu_sll, 0, br_none, 1, 40, 0, 0, 64'h10000000000, 0, 0, 0);
        add_vec(alu_srl, 0, br_none, SIGN_BIT, 63, 0, 0, 1, 0, 0, 0);
        add_vec(alu_sra, 0, br_none, SIGN_BIT, 36, 0, 0, 64'hfffffffff8000000, 0, 0, 0);
        add_vec(alu_and, 0, br_none, 'hff00ff00, 'h0ff00ff0, 0, 0, 'h0f000f00, 0, 0, 0);
        add_vec(alu_or, 0, br_none, 'hff00ff00, 'h0ff00ff0, 0, 0, 'hfff0fff0, 0, 0, 0);
        add_vec(alu_xor, 0, br_none, 'hff00ff00, 'h0ff00ff0, 0, 0, 'hf0f0f0f0, 0, 0, 0);
        add_vec(alu_slt, 0, br_none, -64'd1, 1, 0, 0, 1, 0, 0, 0);
        add_vec(alu_sltu, 0, br_none, -64'd1, 1, 0, 0, 0, 0, 0, 0);
        add_vec(alu_slt, 0, br_none, 1, -64'd1, 0, 0, 0, 0, 0, 0);
        add_vec(alu_sltu, 0, br_none, 1, -64'd1, 0, 0, 1, 0, 0, 0);
        add_vec(alu_pass, 0, br_none, 3, 'h1234, 0, 0, 'h1234, 0, 0, 0);
        // Word mode
        add_vec(alu_add, 1, br_none, 'h7fffffff, 1, 0, 0, 64'hffffffff80000000, 0, 0, 0);
        add_vec(alu_sub, 1, br_none, 0, 1, 0, 0, -64'd1, 0, 0, 0);
        add_vec(alu_sll, 1, br_none, 1, 31, 0, 0, 64'hffffffff80000000, 0, 0, 0);
        add_vec(alu_srl, 1, br_none, 'h80000000, 32, 0, 0, 64'hffffffff80000000, 0, 0, 0);
        add_vec(alu_sra, 1, br_none, 64'h180000000, 4, 0, 0, 64'hfffffffff8000000, 0, 0, 0);
        // Conditional branches, target 0x1040
        add_vec(alu_idle, 0, br_eq, 5, 5, 'h1000, 'h40, 0, 1, 'h1040, 0);
        add_vec(alu_idle, 0, br_ne, 5, 5, 'h1000, 'h40, 0, 0, 'h1040, 0);
        add_vec(alu_idle, 0, br_ne, 5, 6, 'h1000, 'h40, 0, 1, 'h1040, 0);
        add_vec(alu_idle, 0, br_lt, -64'd1, 1, 'h1000, 'h40, 0, 1, 'h1040, 0);
        add_vec(alu_idle, 0, br_lt, 1, -64'd1, 'h1000, 'h40, 0, 0, 'h1040, 0);
        add_vec(alu_idle, 0, br_ge, -64'd1, 1, 'h1000, 'h40, 0, 0, 'h1040, 0);
        add_vec(alu_idle, 0, br_ltu, -64'd1, 1, 'h1000, 'h40, 0, 0, 'h1040, 0);
        add_vec(alu_idle, 0, br_ltu, 1, -64'd1, 'h1000, 'h40, 0, 1, 'h1040, 0);
        add_vec(alu_idle, 0, br_geu, -64'd1, 1, 'h1000, 'h40, 0, 1, 'h1040, 0);
        add_vec(alu_idle, 0, br_geu, 1, -64'd1, 'h1000, 'h40, 0, 0, 'h1040, 0);
        add_vec(alu_idle, 0, br_ge, 7, 7, 'h1000, 'h40, 0, 1, 'h1040, 0);
        // Jumps write pc + 4 whatever the ALU does
        add_vec(alu_add, 0, br_jal, 5, 7, 'h2000, 'h100, 'h2004, 1, 'h2100, 0);
        add_vec(alu_idle, 0, br_jalr, 'h3000, 0, 'h2000, -64'd16, 'h2004, 1, 'h2ff0, 0);
        // Misaligned targets
        add_vec(alu_idle, 0, br_jal, 0, 0, 'h2000, 'h102, 'h2004, 0, 'h2102, 1);
        add_vec(alu_idle, 0, br_jalr, 'h3001, 0, 'h2000, 0, 'h2004, 0, 'h3001, 1);
        add_vec(alu_idle, 0, br_eq, 1, 2, 'h1000, 6, 0, 0, 'h1006, 0);
        add_vec(alu_idle, 0, br_lt, 1, 2, 'h1000, 2, 0, 0, 'h1002, 1);
    endtask

    task automatic apply_vec(input int n);
        op              = vecs[n].op;
        word            = vecs[n].word;
        br_kind         = vecs[n].kind;
        rs1             = vecs[n].rs1;
        rs2             = vecs[n].rs2;
        pc              = vecs[n].pc;
        imm             = vecs[n].imm;
        exp_result      = vecs[n].res;
        exp_redirect    = vecs[n].redir;
        exp_redirect_pc = vecs[n].rpc;
        exp_misaligned  = vecs[n].mis;
        in_valid        = 1'b1;
    endtask

    task automatic run_pass(input logic with_bp);
        logic accepted;
        for (int n = 0; n < NVEC; n++)
        begin
            if (with_bp && ($urandom % 4) == 0)
            begin
                in_valid = 1'b0;
                @(posedge CLK);
                #1;
            end
            apply_vec(n);
            waited   = 0;
            accepted = 1'b0;
            while (!accepted && waited < WAIT_LIMIT)
            begin
                @(negedge CLK);
                accepted = in_ready;
                @(posedge CLK);
                #1;
                waited++;
            end
            if (!accepted)
            begin
                $display("Timed out waiting for in_ready on vector %0d", n);
                tb_errs++;
            end
            else if (!with_bp && waited != 1)
            begin
                $display("Vector %0d waited %0d cycles with out_ready held high", n, waited);
                tb_errs++;
            end
        end
        in_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        RST             = 1'b1;
        in_valid        = 1'b0;
        op              = alu_idle;
        word            = 1'b0;
        br_kind         = br_none;
        rs1             = '0;
        rs2             = '0;
        pc              = '0;
        imm             = '0;
        exp_result      = '0;
        exp_redirect    = 1'b0;
        exp_redirect_pc = '0;
        exp_misaligned  = 1'b0;
        stim_done       = 1'b0;
        backpressure    = 1'b0;
        tb_errs         = 0;
        nvec            = 0;
        void'($urandom(SEED));
        load_vectors();

        repeat (10) @(posedge CLK);
        #1;
        RST = 1'b0;

        @(negedge CLK);
        if (out_valid !== 1'b0)
        begin
            $display("Mismatch out_valid after reset: expected 0, got %h", out_valid);
            tb_errs++;
        end
        if (in_ready !== 1'b1)
        begin
            $display("Mismatch in_ready after reset: expected 1, got %h", in_ready);
            tb_errs++;
        end
        @(posedge CLK);
        #1;

        run_pass(1'b0);
        backpressure = 1'b1;
        run_pass(1'b1);
        stim_done = 1'b1;

        waited = 0;
        while (pending != 0 && !drain_failed && waited < DRAIN_WAIT)
        begin
            @(posedge CLK);
            waited++;
        end
        if (pending != 0 && !drain_failed)
        begin
            $display("Timed out waiting for the last outputs");
            tb_errs++;
        end

        $display("Errors: %0d mismatch, %0d protocol, %0d testbench",
                 mismatch_errs, protocol_errs, tb_errs);
        if (mismatch_errs + protocol_errs + tb_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
ex_pkg.sv
ex_if.sv
int_alu.sv
branch_resolver.sv
ex_result_reg.sv
ex_stage.sv
ex_checker.sv
tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_ex_stage \
    -o tb_ex_stage --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ex_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1
